// File: flist.f
+incdir+include
hdl/rvIsaPkg.sv
hdl/decodePkg.sv
hdl/opDecoder.sv
hdl/immGenerator.sv
hdl/decodeIssue.sv
hdl/decodeStage.sv
test/decodeTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing -f flist.f --top-module decodeTb -Mdir "$BUILD_DIR" -o simDecode
if [ $? -ne 0 ]; then
    echo "Build failed"
    exit 1
fi

"./$BUILD_DIR/simDecode" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi

if grep -q "^Testbench passed$" "$LOG"; then
    exit 0
fi
exit 1

// File: test/decodeTb.sv
module decodeTb;
    import rvIsaPkg::*;
    import decodePkg::*;

    localparam int QUEUE_DEPTH      = 4;
    localparam int DISPATCH_CREDITS = 2;

    logic        clk;
    logic        rst;
    logic        fetchValid;
    fetchPkt_t   fetchPkt;
    logic        fetchCredit;
    logic        issueValid;
    decodedPkt_t issuePkt;
    logic        dispatchCredit;

    decodedPkt_t expQ [$];
    decodedPkt_t expPkt;
    string       currentTest;
    logic [15:0] lfsrState;
    int          fetchCredits;
    int          returnCount;
    int          issueCount;
    int          sentCount;
    int          cycleCount;
    logic        autoReturn;

    decodeStage i_dut (
        .clk            (clk),
        .rst            (rst),
        .fetchValid     (fetchValid),
        .fetchPkt       (fetchPkt),
        .fetchCredit    (fetchCredit),
        .issueValid     (issueValid),
        .issuePkt       (issuePkt),
        .dispatchCredit (dispatchCredit)
    );

    always #50 clk = ~clk;

    task automatic stopWithError(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkValue(input string name, input logic [75:0] exp, input logic [75:0] act);
        if (exp !== act) begin
            $display("mismatch in %s: expected %h, actual %h", name, exp, act);
            $display("Testbench failed");
            $fatal(1);
        end
    endtask

    // 16-bit Fibonacci LFSR with taps 16, 14, 13 and 11 that steps once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
            lfsrState = {lfsrState[14:0], fb};
            r = {r[30:0], fb};
        end
        return r;
    endfunction

    function automatic rvOp_t refOp(input logic [31:0] w);
        logic [2:0] f3;
        logic [6:0] f7;
        rvOp_t      r;
        f3 = w[14:12];
        f7 = w[31:25];
        r = OP_NOP;
        case (w[6:0])
            7'h37: r = OP_LUI;
            7'h17: r = OP_AUIPC;
            7'h6f: r = OP_JAL;
            7'h67: r = (f3 == 3'd0) ? OP_JALR : OP_NOP;
            7'h63: begin
                case (f3)
                    3'd0: r = OP_BEQ;
                    3'd1: r = OP_BNE;
                    3'd4: r = OP_BLT;
                    3'd5: r = OP_BGE;
                    3'd6: r = OP_BLTU;
                    3'd7: r = OP_BGEU;
                    default: r = OP_NOP;
                endcase
            end
            7'h03: begin
                case (f3)
                    3'd0: r = OP_LB;
                    3'd1: r = OP_LH;
                    3'd2: r = OP_LW;
                    3'd4: r = OP_LBU;
                    3'd5: r = OP_LHU;
                    default: r = OP_NOP;
                endcase
            end
            7'h23: begin
                case (f3)
                    3'd0: r = OP_SB;
                    3'd1: r = OP_SH;
                    3'd2: r = OP_SW;
                    default: r = OP_NOP;
                endcase
            end
            7'h13: begin
                case (f3)
                    3'd0: r = OP_ADDI;
                    3'd2: r = OP_SLTI;
                    3'd3: r = OP_SLTIU;
                    3'd4: r = OP_XORI;
                    3'd6: r = OP_ORI;
                    3'd7: r = OP_ANDI;
                    3'd1: r = (f7 == 7'h00) ? OP_SLLI : OP_NOP;
                    default: r = (f7 == 7'h00) ? OP_SRLI : (f7 == 7'h20) ? OP_SRAI : OP_NOP;
                endcase
            end
            7'h33: begin
                // Only bit 30 of the word selects the alternate ALU ops
                case (f3)
                    3'd0: r = f7[5] ? OP_SUB : OP_ADD;
                    3'd5: r = f7[5] ? OP_SRA : OP_SRL;
                    3'd1: r = f7[5] ? OP_NOP : OP_SLL;
                    3'd2: r = f7[5] ? OP_NOP : OP_SLT;
                    3'd3: r = f7[5] ? OP_NOP : OP_SLTU;
                    3'd4: r = f7[5] ? OP_NOP : OP_XOR;
                    3'd6: r = f7[5] ? OP_NOP : OP_OR;
                    default: r = f7[5] ? OP_NOP : OP_AND;
                endcase
            end
            default: r = OP_NOP;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] refImm(input logic [31:0] w);
        case (w[6:0])
            7'h67, 7'h03: return {{20{w[31]}}, w[31:20]};
            7'h13: begin
                if (w[14:12] == 3'd1 || w[14:12] == 3'd5) begin
                    return {27'b0, w[24:20]};
                end
                return {{20{w[31]}}, w[31:20]};
            end
            7'h23: return {{20{w[31]}}, w[31:25], w[11:7]};
            7'h63: return {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
            7'h6f: return {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
            7'h37, 7'h17: return {w[31:12], 12'b0};
            default: return 32'b0;
        endcase
    endfunction

    task automatic sendPkt(input logic [31:0] w);
        decodedPkt_t e;
        @(posedge clk);
        #10;
        while (fetchCredits == 0) begin
            fetchValid = 1'b0;
            @(posedge clk);
            #10;
        end
        fetchPkt.instr    = w;
        fetchPkt.pc       = {30'(randBits(30)), 2'b00};
        fetchPkt.predJump = 1'(randBits(1));
        e.op       = refOp(w);
        e.rs1      = w[19:15];
        e.rs2      = w[24:20];
        e.rd       = w[11:7];
        e.imm      = refImm(w);
        e.pc       = fetchPkt.pc;
        e.predJump = fetchPkt.predJump;
        expQ.push_back(e);
        fetchValid = 1'b1;
        fetchCredits--;
        sentCount++;
    endtask

    task automatic drain();
        @(posedge clk);
        #10;
        fetchValid = 1'b0;
        while (expQ.size() > 0 || issueCount > returnCount) begin
            @(posedge clk);
            #20;
        end
    endtask

    task automatic sendExpectingOp(input logic [6:0] opc, input logic [2:0] f3,
                                   input logic [6:0] f7, input rvOp_t expOp);
        logic [31:0] w;
        w = {f7, 10'(randBits(10)), f3, 5'(randBits(5)), opc};
        checkValue(currentTest, 76'(expOp), 76'(refOp(w)));
        sendPkt(w);
    endtask

    task automatic testReset();
        currentTest = "reset state";
        repeat (3) begin
            @(negedge clk);
            checkValue(currentTest, 76'(0), 76'({issueValid, fetchCredit}));
        end
        @(posedge clk);
        #10;
        rst = 1'b0;
        repeat (5) begin
            @(negedge clk);
            checkValue(currentTest, 76'(0), 76'({issueValid, fetchCredit}));
        end
    endtask

    task automatic testOpcodes();
        currentTest = "opcode coverage";
        sendExpectingOp(7'h37, 3'd0, 7'h00, OP_LUI);
        sendExpectingOp(7'h17, 3'd0, 7'h00, OP_AUIPC);
        sendExpectingOp(7'h6f, 3'd0, 7'h00, OP_JAL);
        sendExpectingOp(7'h67, 3'd0, 7'h00, OP_JALR);
        sendExpectingOp(7'h63, 3'd0, 7'h00, OP_BEQ);
        sendExpectingOp(7'h63, 3'd1, 7'h00, OP_BNE);
        sendExpectingOp(7'h63, 3'd4, 7'h00, OP_BLT);
        sendExpectingOp(7'h63, 3'd5, 7'h00, OP_BGE);
        sendExpectingOp(7'h63, 3'd6, 7'h00, OP_BLTU);
        sendExpectingOp(7'h63, 3'd7, 7'h00, OP_BGEU);
        sendExpectingOp(7'h03, 3'd0, 7'h00, OP_LB);
        sendExpectingOp(7'h03, 3'd1, 7'h00, OP_LH);
        sendExpectingOp(7'h03, 3'd2, 7'h00, OP_LW);
        sendExpectingOp(7'h03, 3'd4, 7'h00, OP_LBU);
        sendExpectingOp(7'h03, 3'd5, 7'h00, OP_LHU);
        sendExpectingOp(7'h23, 3'd0, 7'h00, OP_SB);
        sendExpectingOp(7'h23, 3'd1, 7'h00, OP_SH);
        sendExpectingOp(7'h23, 3'd2, 7'h00, OP_SW);
        sendExpectingOp(7'h13, 3'd0, 7'h7f, OP_ADDI);
        sendExpectingOp(7'h13, 3'd2, 7'h00, OP_SLTI);
        sendExpectingOp(7'h13, 3'd3, 7'h00, OP_SLTIU);
        sendExpectingOp(7'h13, 3'd4, 7'h00, OP_XORI);
        sendExpectingOp(7'h13, 3'd6, 7'h00, OP_ORI);
        sendExpectingOp(7'h13, 3'd7, 7'h00, OP_ANDI);
        sendExpectingOp(7'h13, 3'd1, 7'h00, OP_SLLI);
        sendExpectingOp(7'h13, 3'd5, 7'h00, OP_SRLI);
        sendExpectingOp(7'h13, 3'd5, 7'h20, OP_SRAI);
        sendExpectingOp(7'h33, 3'd0, 7'h00, OP_ADD);
        sendExpectingOp(7'h33, 3'd0, 7'h20, OP_SUB);
        sendExpectingOp(7'h33, 3'd1, 7'h00, OP_SLL);
        sendExpectingOp(7'h33, 3'd2, 7'h00, OP_SLT);
        sendExpectingOp(7'h33, 3'd3, 7'h00, OP_SLTU);
        sendExpectingOp(7'h33, 3'd4, 7'h00, OP_XOR);
        sendExpectingOp(7'h33, 3'd5, 7'h00, OP_SRL);
        sendExpectingOp(7'h33, 3'd5, 7'h20, OP_SRA);
        sendExpectingOp(7'h33, 3'd6, 7'h00, OP_OR);
        sendExpectingOp(7'h33, 3'd7, 7'h00, OP_AND);
        drain();
    endtask

    task automatic testImmediates();
        logic [6:0]  opcodes [6];
        logic [31:0] w;
        opcodes = '{7'h13, 7'h23, 7'h63, 7'h37, 7'h6f, 7'h67};
        currentTest = "immediates";
        foreach (opcodes[k]) begin
            for (int i = 0; i < 64; i++) begin
                w = randBits(32);
                w[6:0] = opcodes[k];
                // Keep the funct fields on legal values for each format
                if (opcodes[k] == 7'h13 && (w[14:12] == 3'd1 || w[14:12] == 3'd5)) begin
                    w[31:25] = {1'b0, w[30], 5'b0};
                end else if (opcodes[k] == 7'h23) begin
                    w[14:12] = {1'b0, w[13] & ~w[12], w[12]};
                end else if (opcodes[k] == 7'h63 && w[14:13] == 2'b01) begin
                    w[14] = 1'b1;
                end else if (opcodes[k] == 7'h67) begin
                    w[14:12] = 3'd0;
                end
                sendPkt(w);
            end
        end
        drain();
    endtask

    task automatic testIllegal();
        logic [31:0] words [10];
        words = '{32'h0000_000f, 32'h0000_0073, 32'h0000_0000, 32'h1234_a0e3,
                  32'h00c5_b583, 32'h00c5_c5a3, 32'h0225_1593, 32'h4225_5593,
                  32'h40a5_95b3, 32'h0005_9567};
        currentTest = "illegal encodings";
        foreach (words[i]) begin
            checkValue(currentTest, 76'(OP_NOP), 76'(refOp(words[i])));
            sendPkt(words[i]);
        end
        drain();
    endtask

    task automatic testCredits();
        int baseIssues;
        currentTest = "credits and order";
        @(negedge clk);
        autoReturn = 1'b0;
        baseIssues = issueCount;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            sendPkt(32'h0010_0093 + (i << 7));
        end
        @(posedge clk);
        #10;
        fetchValid = 1'b0;
        repeat (10) @(posedge clk);
        checkValue(currentTest, 76'(DISPATCH_CREDITS), 76'(issueCount - baseIssues));
        checkValue(currentTest, 76'(DISPATCH_CREDITS), 76'(fetchCredits));
        @(negedge clk);
        autoReturn = 1'b1;
        drain();
        checkValue(currentTest, 76'(QUEUE_DEPTH), 76'(issueCount - baseIssues));
        checkValue(currentTest, 76'(QUEUE_DEPTH), 76'(fetchCredits));
    endtask

    // Outputs settle after the rising edge and are read at the falling edge
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            if (issueValid === 1'b1) begin
                if (expQ.size() == 0) begin
                    stopWithError("Error: issueValid was seen while no packet was expected");
                end else begin
                    expPkt = expQ.pop_front();
                    checkValue(currentTest, expPkt, issuePkt);
                    issueCount++;
                end
            end
            if (fetchCredit === 1'b1) begin
                if (fetchCredits >= QUEUE_DEPTH) begin
                    stopWithError("Error: fetchCredit pulsed while all fetch credits were held");
                end else begin
                    fetchCredits++;
                end
            end
        end
    end

    always @(posedge clk) begin
        #10;
        if (autoReturn && issueCount > returnCount) begin
            dispatchCredit = 1'b1;
            returnCount++;
        end else begin
            dispatchCredit = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount > 20 * sentCount + 200) begin
            stopWithError("Error: timeout, the DUT stopped issuing packets");
        end
    end

    initial begin
        clk            = 1'b0;
        rst            = 1'b1;
        fetchValid     = 1'b0;
        fetchPkt       = '0;
        dispatchCredit = 1'b0;
        lfsrState      = 16'd57;
        fetchCredits   = QUEUE_DEPTH;
        returnCount    = 0;
        issueCount     = 0;
        sentCount      = 0;
        cycleCount     = 0;
        autoReturn     = 1'b1;
        currentTest    = "startup";
        testReset();
        testOpcodes();
        testImmediates();
        testIllegal();
        testCredits();
        if (expQ.size() == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Error: packets were still expected at the end of the run");
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

// File: hdl/decodeStage.sv
module decodeStage #(
    parameter int QUEUE_DEPTH      = 4,
    parameter int DISPATCH_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchValid,
    input  decodePkg::fetchPkt_t   fetchPkt,
    output logic                   fetchCredit,
    output logic                   issueValid,
    output decodePkg::decodedPkt_t issuePkt,
    input  logic                   dispatchCredit
);
    import rvIsaPkg::*;

    rvOp_t       op;
    logic [31:0] imm;

    // Both decoders look at the same word in parallel
    opDecoder i_opDecoder (
        .instr (fetchPkt.instr),
        .op    (op)
    );

    immGenerator i_immGenerator (
        .instr (fetchPkt.instr),
        .imm   (imm)
    );

    decodeIssue #(
        .QUEUE_DEPTH      (QUEUE_DEPTH),
        .DISPATCH_CREDITS (DISPATCH_CREDITS)
    ) i_decodeIssue (
        .clk            (clk),
        .rst            (rst),
        .fetchValid     (fetchValid),
        .fetchPkt       (fetchPkt),
        .op             (op),
        .imm            (imm),
        .fetchCredit    (fetchCredit),
        .issueValid     (issueValid),
        .issuePkt       (issuePkt),
        .dispatchCredit (dispatchCredit)
    );

endmodule

// File: hdl/decodeIssue.sv
module decodeIssue #(
    parameter int QUEUE_DEPTH      = 4,
    parameter int DISPATCH_CREDITS = 2
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   fetchValid,
    input  decodePkg::fetchPkt_t   fetchPkt,
    input  rvIsaPkg::rvOp_t        op,
    input  logic [31:0]            imm,
    output logic                   fetchCredit,
    output logic                   issueValid,
    output decodePkg::decodedPkt_t issuePkt,
    input  logic                   dispatchCredit
);
    import decodePkg::*;

    localparam int PTR_W    = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W    = $clog2(QUEUE_DEPTH + 1);
    localparam int CREDIT_W = $clog2(DISPATCH_CREDITS + 1);

    decodedPkt_t         queueMem [QUEUE_DEPTH];
    decodedPkt_t         newPkt;
    logic [PTR_W-1:0]    wrPtr;
    logic [PTR_W-1:0]    rdPtr;
    logic [CNT_W-1:0]    count;
    logic [CREDIT_W-1:0] creditCnt;
    logic                queueEmpty;
    logic                loadSlot;
    logic                pushQueue;
    logic                popQueue;

    function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(QUEUE_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_comb begin
        newPkt.op       = op;
        newPkt.rs1      = fetchPkt.instr.rType.rs1;
        newPkt.rs2      = fetchPkt.instr.rType.rs2;
        newPkt.rd       = fetchPkt.instr.rType.rd;
        newPkt.imm      = imm;
        newPkt.pc       = fetchPkt.pc;
        newPkt.predJump = fetchPkt.predJump;
    end

    assign queueEmpty = (count == '0);
    assign loadSlot   = (creditCnt != '0) && (!queueEmpty || fetchValid);
    // An empty queue lets the incoming packet go straight to the issue slot
    assign pushQueue  = fetchValid && !(loadSlot && queueEmpty);
    assign popQueue   = loadSlot && !queueEmpty;

    always_ff @(posedge clk) begin
        if (pushQueue) begin
            queueMem[wrPtr] <= newPkt;
        end
        if (loadSlot) begin
            issuePkt <= queueEmpty ? newPkt : queueMem[rdPtr];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wrPtr      <= '0;
            rdPtr      <= '0;
            count      <= '0;
            creditCnt  <= CREDIT_W'(DISPATCH_CREDITS);
            issueValid <= 1'b0;
        end else begin
            if (pushQueue) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (popQueue) begin
                rdPtr <= nextPtr(rdPtr);
            end
            if (pushQueue && !popQueue) begin
                count <= count + 1'b1;
            end else if (popQueue && !pushQueue) begin
                count <= count - 1'b1;
            end
            // A credit returned in the same cycle as one is spent leaves the count alone
            if (loadSlot && !dispatchCredit) begin
                creditCnt <= creditCnt - 1'b1;
            end else if (dispatchCredit && !loadSlot) begin
                creditCnt <= creditCnt + 1'b1;
            end
            issueValid <= loadSlot;
        end
    end

    // Every issue frees exactly one entry on the fetch side
    assign fetchCredit = issueValid;

endmodule

// File: hdl/immGenerator.sv
module immGenerator (
    input  rvIsaPkg::rvInstr_t instr,
    output logic [31:0]        imm
);
    import rvIsaPkg::*;

    logic [31:0] immI;
    logic [31:0] immS;
    logic [31:0] immB;
    logic [31:0] immJ;
    logic [31:0] immU;
    logic        isShift;

    assign immI = {{20{instr.iType.imm[11]}}, instr.iType.imm};
    assign immS = {{20{instr.sType.immHi[6]}}, instr.sType.immHi, instr.sType.immLo};
    assign immB = {{19{instr.bType.imm12}}, instr.bType.imm12, instr.bType.imm11,
                   instr.bType.imm10to5, instr.bType.imm4to1, 1'b0};
    assign immJ = {{11{instr.jType.imm20}}, instr.jType.imm20, instr.jType.imm19to12,
                   instr.jType.imm11, instr.jType.imm10to1, 1'b0};
    assign immU = {instr.uType.imm, 12'b0};

    assign isShift = (instr.iType.funct3 == F3_SLL) || (instr.iType.funct3 == F3_SR);

    always_comb begin
        case (instr.rType.opcode)
            OPC_JALR, OPC_LOAD: imm = immI;
            OPC_OP_IMM: begin
                // Shifts carry an unsigned shift amount instead of a signed value
                if (isShift) begin
                    imm = {27'b0, instr.iType.imm[4:0]};
                end else begin
                    imm = immI;
                end
            end
            OPC_STORE:          imm = immS;
            OPC_BRANCH:         imm = immB;
            OPC_JAL:            imm = immJ;
            OPC_LUI, OPC_AUIPC: imm = immU;
            default:            imm = '0;
        endcase
    end

endmodule

// File: hdl/opDecoder.sv
module opDecoder (
    input  rvIsaPkg::rvInstr_t instr,
    output rvIsaPkg::rvOp_t    op
);
    import rvIsaPkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       altBit;

    assign opcode = instr.rType.opcode;
    assign funct3 = instr.rType.funct3;
    assign funct7 = instr.rType.funct7;
    // Bit 30 of the word separates SUB from ADD and SRA from SRL
    assign altBit = funct7[5];

    always_comb begin
        op = OP_NOP;
        case (opcode)
            OPC_LUI:   op = OP_LUI;
            OPC_AUIPC: op = OP_AUIPC;
            OPC_JAL:   op = OP_JAL;
            OPC_JALR: begin
                if (funct3 == F3_JALR) begin
                    op = OP_JALR;
                end
            end
            OPC_BRANCH: begin
                case (funct3)
                    F3_BEQ:  op = OP_BEQ;
                    F3_BNE:  op = OP_BNE;
                    F3_BLT:  op = OP_BLT;
                    F3_BGE:  op = OP_BGE;
                    F3_BLTU: op = OP_BLTU;
                    F3_BGEU: op = OP_BGEU;
                    default: op = OP_NOP;
                endcase
            end
            OPC_LOAD: begin
                case (funct3)
                    F3_BYTE:  op = OP_LB;
                    F3_HALF:  op = OP_LH;
                    F3_WORD:  op = OP_LW;
                    F3_BYTEU: op = OP_LBU;
                    F3_HALFU: op = OP_LHU;
                    default:  op = OP_NOP;
                endcase
            end
            OPC_STORE: begin
                case (funct3)
                    F3_BYTE: op = OP_SB;
                    F3_HALF: op = OP_SH;
                    F3_WORD: op = OP_SW;
                    default: op = OP_NOP;
                endcase
            end
            OPC_OP_IMM: begin
                case (funct3)
                    F3_ADD:  op = OP_ADDI;
                    F3_SLT:  op = OP_SLTI;
                    F3_SLTU: op = OP_SLTIU;
                    F3_XOR:  op = OP_XORI;
                    F3_OR:   op = OP_ORI;
                    F3_AND:  op = OP_ANDI;
                    // Shift amounts only use 5 bits so the upper field must be clean
                    F3_SLL: begin
                        if (funct7 == F7_BASE) begin
                            op = OP_SLLI;
                        end
                    end
                    F3_SR: begin
                        if (funct7 == F7_BASE) begin
                            op = OP_SRLI;
                        end else if (funct7 == F7_ALT) begin
                            op = OP_SRAI;
                        end
                    end
                    default: op = OP_NOP;
                endcase
            end
            OPC_OP: begin
                case (funct3)
                    F3_ADD: op = altBit ? OP_SUB : OP_ADD;
                    F3_SR:  op = altBit ? OP_SRA : OP_SRL;
                    F3_SLL: begin
                        if (!altBit) begin
                            op = OP_SLL;
                        end
                    end
                    F3_SLT: begin
                        if (!altBit) begin
                            op = OP_SLT;
                        end
                    end
                    F3_SLTU: begin
                        if (!altBit) begin
                            op = OP_SLTU;
                        end
                    end
                    F3_XOR: begin
                        if (!altBit) begin
                            op = OP_XOR;
                        end
                    end
                    F3_OR: begin
                        if (!altBit) begin
                            op = OP_OR;
                        end
                    end
                    F3_AND: begin
                        if (!altBit) begin
                            op = OP_AND;
                        end
                    end
                    default: op = OP_NOP;
                endcase
            end
            default: op = OP_NOP;
        endcase
    end

endmodule

// File: hdl/decodePkg.sv
package decodePkg;

    // What the fetch unit hands over for each instruction
    typedef struct packed {
        rvIsaPkg::rvInstr_t instr;
        logic [31:0]        pc;
        logic               predJump;
    } fetchPkt_t;

    // Decoded instruction on its way to dispatch
    typedef struct packed {
        rvIsaPkg::rvOp_t    op;
        rvIsaPkg::regName_t rs1;
        rvIsaPkg::regName_t rs2;
        rvIsaPkg::regName_t rd;
        logic [31:0]        imm;
        logic [31:0]        pc;
        logic               predJump;
    } decodedPkt_t;

endpackage

// File: hdl/rvIsaPkg.sv
package rvIsaPkg;

    `include "rvEncodings.svh"

    typedef logic [4:0] regName_t;

    // One instruction word seen through each of the six base formats
    typedef union packed {
        struct packed {
            logic [6:0] funct7;
            regName_t   rs2;
            regName_t   rs1;
            logic [2:0] funct3;
            regName_t   rd;
            logic [6:0] opcode;
        } rType;
        struct packed {
            logic [11:0] imm;
            regName_t    rs1;
            logic [2:0]  funct3;
            regName_t    rd;
            logic [6:0]  opcode;
        } iType;
        struct packed {
            logic [6:0] immHi;
            regName_t   rs2;
            regName_t   rs1;
            logic [2:0] funct3;
            logic [4:0] immLo;
            logic [6:0] opcode;
        } sType;
        struct packed {
            logic       imm12;
            logic [5:0] imm10to5;
            regName_t   rs2;
            regName_t   rs1;
            logic [2:0] funct3;
            logic [3:0] imm4to1;
            logic       imm11;
            logic [6:0] opcode;
        } bType;
        struct packed {
            logic [19:0] imm;
            regName_t    rd;
            logic [6:0]  opcode;
        } uType;
        struct packed {
            logic       imm20;
            logic [9:0] imm10to1;
            logic       imm11;
            logic [7:0] imm19to12;
            regName_t   rd;
            logic [6:0] opcode;
        } jType;
    } rvInstr_t;

    // Internal operation codes where OP_NOP also covers every unsupported encoding
    typedef enum logic [5:0] {
        OP_NOP,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
        OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
        OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND
    } rvOp_t;

endpackage

// File: include/rvEncodings.svh
`ifndef RV_ENCODINGS_SVH
`define RV_ENCODINGS_SVH

// Major opcodes of the base integer ISA
localparam logic [6:0] OPC_LUI    = 7'b0110111;
localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
localparam logic [6:0] OPC_JAL    = 7'b1101111;
localparam logic [6:0] OPC_JALR   = 7'b1100111;
localparam logic [6:0] OPC_BRANCH = 7'b1100011;
localparam logic [6:0] OPC_LOAD   = 7'b0000011;
localparam logic [6:0] OPC_STORE  = 7'b0100011;
localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
localparam logic [6:0] OPC_OP     = 7'b0110011;

localparam logic [2:0] F3_JALR = 3'b000;

localparam logic [2:0] F3_BEQ  = 3'b000;
localparam logic [2:0] F3_BNE  = 3'b001;
localparam logic [2:0] F3_BLT  = 3'b100;
localparam logic [2:0] F3_BGE  = 3'b101;
localparam logic [2:0] F3_BLTU = 3'b110;
localparam logic [2:0] F3_BGEU = 3'b111;

// Loads and stores share the size encoding
localparam logic [2:0] F3_BYTE  = 3'b000;
localparam logic [2:0] F3_HALF  = 3'b001;
localparam logic [2:0] F3_WORD  = 3'b010;
localparam logic [2:0] F3_BYTEU = 3'b100;
localparam logic [2:0] F3_HALFU = 3'b101;

// ALU operations, for both the register and the immediate forms
localparam logic [2:0] F3_ADD  = 3'b000;
localparam logic [2:0] F3_SLL  = 3'b001;
localparam logic [2:0] F3_SLT  = 3'b010;
localparam logic [2:0] F3_SLTU = 3'b011;
localparam logic [2:0] F3_XOR  = 3'b100;
localparam logic [2:0] F3_SR   = 3'b101;
localparam logic [2:0] F3_OR   = 3'b110;
localparam logic [2:0] F3_AND  = 3'b111;

localparam logic [6:0] F7_BASE = 7'b0000000;
localparam logic [6:0] F7_ALT  = 7'b0100000;

`endif
